//--- src/riscv_pkg.sv
package riscv_pkg;

    // immediate formats understood by the extender.
    typedef enum logic [2:0] {
        imm_i = 3'd0,             // loads, alu immediates, jalr.
        imm_s = 3'd1,             // stores.
        imm_b = 3'd2,             // conditional branches.
        imm_j = 3'd3,             // jal.
        imm_u = 3'd4              // lui.
    } imm_src_e;

    // alu operations.
    typedef enum logic [3:0] {
        alu_add    = 4'd0,
        alu_sub    = 4'd1,
        alu_and    = 4'd2,
        alu_or     = 4'd3,
        alu_xor    = 4'd4,
        alu_slt    = 4'd5,        // signed compare.
        alu_sll    = 4'd6,
        alu_srl    = 4'd7,
        alu_pass_b = 4'd8         // operand b straight through.
    } alu_op_e;

    // alu operand sources, shared by both operand muxes.
    typedef enum logic [1:0] {
        alu_src_reg_1   = 2'd0,
        alu_src_reg_2   = 2'd1,
        alu_src_ext_imm = 2'd2,
        alu_src_pc      = 2'd3
    } alu_src_e;

    // register write-back sources.
    typedef enum logic [1:0] {
        res_src_alu_out   = 2'd0,
        res_src_pc_plus_4 = 2'd1, // link value for jumps.
        res_src_ext_imm   = 2'd2,
        res_src_mem       = 2'd3
    } res_src_e;

    // next pc sources.
    typedef enum logic [1:0] {
        pc_src_plus_4       = 2'd0,
        pc_src_plus_off     = 2'd1, // taken branch and jal.
        pc_src_reg_plus_off = 2'd2  // jalr.
    } pc_src_e;

    typedef struct packed {
        logic zero;               // a - b is zero.
        logic negative;           // sign of a - b.
        logic carry;              // no unsigned borrow.
        logic overflow;           // signed overflow of a - b.
    } alu_flags_t;

    typedef struct packed {
        logic     reg_we;
        logic     mem_we;
        imm_src_e imm_src;
        alu_op_e  alu_ctrl;
        alu_src_e alu_src_a;
        alu_src_e alu_src_b;
        res_src_e result_src;
        pc_src_e  pc_src;
    } ctrl_t;

    // major opcodes, instr[6:0].
    localparam logic [6:0] op_load   = 7'b0000011;
    localparam logic [6:0] op_store  = 7'b0100011;
    localparam logic [6:0] op_imm    = 7'b0010011;
    localparam logic [6:0] op_reg    = 7'b0110011;
    localparam logic [6:0] op_branch = 7'b1100011;
    localparam logic [6:0] op_jal    = 7'b1101111;
    localparam logic [6:0] op_jalr   = 7'b1100111;
    localparam logic [6:0] op_lui    = 7'b0110111;

endpackage

//--- src/alu.sv
module alu import riscv_pkg::*; (
    input  logic [31:0] a,
    input  logic [31:0] b,
    input  alu_op_e     alu_ctrl,
    output logic [31:0] result,
    output alu_flags_t  flags
);

    logic [32:0] diff;        // a - b with borrow in bit 32.
    logic [4:0]  shamt;       // shift amount.
    logic        lt_signed;   // a < b, signed.

    assign diff      = {1'b0, a} - {1'b0, b};
    assign shamt     = b[4:0];
    assign lt_signed = $signed(a) < $signed(b);

    always_comb begin
        case (alu_ctrl)
            alu_add:    result = a + b;
            alu_sub:    result = diff[31:0];
            alu_and:    result = a & b;
            alu_or:     result = a | b;
            alu_xor:    result = a ^ b;
            alu_slt:    result = {31'd0, lt_signed};
            alu_sll:    result = a << shamt;
            alu_srl:    result = a >> shamt;
            alu_pass_b: result = b;
            default:    result = 32'hffffffff; // undefined op.
        endcase
    end

    // flags always describe a - b, so a branch only needs to pick sub
    // and look at the flags.
    assign flags.zero     = (diff[31:0] == 32'd0);
    assign flags.negative = diff[31];
    assign flags.carry    = ~diff[32];                    // borrow inverted.
    assign flags.overflow = (a[31] ^ b[31]) & (a[31] ^ diff[31]); // signs differ, sign flips.

endmodule

//--- src/extend.sv
module extend import riscv_pkg::*; (
    input  logic [31:0] instr,
    input  imm_src_e    imm_src,
    output logic [31:0] ext_imm
);

    logic sign;               // instr[31] is the sign for every format.

    assign sign = instr[31];

    always_comb begin
        case (imm_src)
            imm_i:   ext_imm = {{20{sign}}, instr[31:20]};
            imm_s:   ext_imm = {{20{sign}}, instr[31:25], instr[11:7]};
            imm_b:   ext_imm = {{19{sign}}, sign, instr[7], instr[30:25],
                                instr[11:8], 1'b0};  // halfword offset.
            imm_j:   ext_imm = {{11{sign}}, sign, instr[19:12], instr[20],
                                instr[30:21], 1'b0}; // halfword offset.
            imm_u:   ext_imm = {instr[31:12], 12'd0}; // upper 20 bits.
            default: ext_imm = 32'hffffffff;
        endcase
    end

endmodule

//--- src/regfile.sv
module regfile (
    input  logic        clk,
    input  logic [4:0]  rs1,
    input  logic [4:0]  rs2,
    input  logic [4:0]  rd,
    input  logic [31:0] wr_data,
    input  logic        we,
    output logic [31:0] rd1,
    output logic [31:0] rd2
);

    logic [31:0] regs [31:1]; // x0 has no storage.

    always_ff @(posedge clk) begin
        if (we && (rd != 5'd0)) begin // writes to x0 are dropped.
            regs[rd] <= wr_data;
        end
    end

    // reads are combinational, x0 reads as zero.
    assign rd1 = (rs1 == 5'd0) ? 32'd0 : regs[rs1];
    assign rd2 = (rs2 == 5'd0) ? 32'd0 : regs[rs2];

endmodule

//--- src/datapath.sv
module datapath import riscv_pkg::*; #(
    parameter logic [31:0] reset_pc = 32'h0000_0000
) (
    input  logic        clk,
    input  logic        rst,
    input  logic [31:0] instr,
    input  logic [31:0] read_data,
    input  ctrl_t       ctrl,
    output logic [31:0] pc,
    output logic [31:0] alu_out,
    output alu_flags_t  alu_flags,
    output logic [31:0] write_data
);

    logic [31:0] pc_next;
    logic [31:0] pc_plus_4;
    logic [31:0] pc_plus_off;
    logic [31:0] pc_reg_plus_off;
    logic [31:0] ext_imm;
    logic [31:0] reg_rd1;
    logic [31:0] reg_rd2;
    logic [31:0] reg_wr_data;
    logic [31:0] alu_op_a;
    logic [31:0] alu_op_b;

    // next pc candidates.
    assign pc_plus_4       = pc + 32'd4;
    assign pc_plus_off     = pc + ext_imm;
    assign pc_reg_plus_off = (reg_rd1 + ext_imm) & ~32'd1; // jalr clears bit 0.

    always_comb begin
        case (ctrl.pc_src)
            pc_src_plus_4:       pc_next = pc_plus_4;
            pc_src_plus_off:     pc_next = pc_plus_off;
            pc_src_reg_plus_off: pc_next = pc_reg_plus_off;
            default:             pc_next = 32'hffffffff;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= reset_pc;       // held here for the whole reset.
        end else begin
            pc <= pc_next;
        end
    end

    // write-back select.
    always_comb begin
        case (ctrl.result_src)
            res_src_alu_out:   reg_wr_data = alu_out;
            res_src_pc_plus_4: reg_wr_data = pc_plus_4;
            res_src_ext_imm:   reg_wr_data = ext_imm;
            res_src_mem:       reg_wr_data = read_data;
            default:           reg_wr_data = 32'hffffffff;
        endcase
    end

    regfile u_regfile (
        .clk     (clk),
        .rs1     (instr[19:15]),
        .rs2     (instr[24:20]),
        .rd      (instr[11:7]),
        .wr_data (reg_wr_data),
        .we      (ctrl.reg_we),
        .rd1     (reg_rd1),
        .rd2     (reg_rd2)
    );

    assign write_data = reg_rd2; // stores always take rs2.

    extend u_extend (
        .instr   (instr),
        .imm_src (ctrl.imm_src),
        .ext_imm (ext_imm)
    );

    // operand a select.
    always_comb begin
        case (ctrl.alu_src_a)
            alu_src_reg_1:   alu_op_a = reg_rd1;
            alu_src_reg_2:   alu_op_a = reg_rd2;
            alu_src_ext_imm: alu_op_a = ext_imm;
            alu_src_pc:      alu_op_a = pc;
            default:         alu_op_a = 32'hffffffff;
        endcase
    end

    // operand b select.
    always_comb begin
        case (ctrl.alu_src_b)
            alu_src_reg_1:   alu_op_b = reg_rd1;
            alu_src_reg_2:   alu_op_b = reg_rd2;
            alu_src_ext_imm: alu_op_b = ext_imm;
            alu_src_pc:      alu_op_b = pc;
            default:         alu_op_b = 32'hffffffff;
        endcase
    end

    alu u_alu (
        .a        (alu_op_a),
        .b        (alu_op_b),
        .alu_ctrl (ctrl.alu_ctrl),
        .result   (alu_out),
        .flags    (alu_flags)
    );

endmodule

//--- src/control_unit.sv
module control_unit import riscv_pkg::*; (
    input  logic        rst,
    input  logic [31:0] instr,
    input  alu_flags_t  alu_flags,
    output ctrl_t       ctrl
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic       funct7_5;     // selects sub among r-type adds.
    logic       taken;        // branch condition met.
    alu_op_e    arith_op;     // shared op for op_imm and op_reg.

    assign opcode   = instr[6:0];
    assign funct3   = instr[14:12];
    assign funct7_5 = instr[30];

    // branch resolution from the a - b flags.
    always_comb begin
        case (funct3)
            3'b000:  taken = alu_flags.zero;                         // beq.
            3'b001:  taken = ~alu_flags.zero;                        // bne.
            3'b100:  taken = alu_flags.negative ^ alu_flags.overflow; // blt.
            default: taken = 1'b0;                                   // not supported.
        endcase
    end

    // funct3 decode; sub only exists in register form.
    always_comb begin
        case (funct3)
            3'b000:  arith_op = (opcode == op_reg && funct7_5) ? alu_sub : alu_add;
            3'b001:  arith_op = alu_sll;
            3'b010:  arith_op = alu_slt;
            3'b100:  arith_op = alu_xor;
            3'b101:  arith_op = alu_srl;
            3'b110:  arith_op = alu_or;
            3'b111:  arith_op = alu_and;
            default: arith_op = alu_add;
        endcase
    end

    always_comb begin
        // defaults give a no-op that steps the pc.
        ctrl.reg_we     = 1'b0;
        ctrl.mem_we     = 1'b0;
        ctrl.imm_src    = imm_i;
        ctrl.alu_ctrl   = alu_add;
        ctrl.alu_src_a  = alu_src_reg_1;
        ctrl.alu_src_b  = alu_src_ext_imm;
        ctrl.result_src = res_src_alu_out;
        ctrl.pc_src     = pc_src_plus_4;

        case (opcode)
            op_load: begin
                ctrl.reg_we     = 1'b1;       // rs1 + imm addresses memory.
                ctrl.result_src = res_src_mem;
            end
            op_store: begin
                ctrl.mem_we  = 1'b1;
                ctrl.imm_src = imm_s;
            end
            op_imm: begin
                ctrl.reg_we   = 1'b1;
                ctrl.alu_ctrl = arith_op;
            end
            op_reg: begin
                ctrl.reg_we    = 1'b1;
                ctrl.alu_ctrl  = arith_op;
                ctrl.alu_src_b = alu_src_reg_2;
            end
            op_branch: begin
                ctrl.imm_src   = imm_b;
                ctrl.alu_ctrl  = alu_sub;     // compare rs1 with rs2.
                ctrl.alu_src_b = alu_src_reg_2;
                ctrl.pc_src    = taken ? pc_src_plus_off : pc_src_plus_4;
            end
            op_jal: begin
                ctrl.reg_we     = 1'b1;
                ctrl.imm_src    = imm_j;
                ctrl.result_src = res_src_pc_plus_4; // link.
                ctrl.pc_src     = pc_src_plus_off;
            end
            op_jalr: begin
                ctrl.reg_we     = 1'b1;
                ctrl.result_src = res_src_pc_plus_4; // link.
                ctrl.pc_src     = pc_src_reg_plus_off;
            end
            op_lui: begin
                ctrl.reg_we    = 1'b1;
                ctrl.imm_src   = imm_u;
                ctrl.alu_ctrl  = alu_pass_b;  // immediate through the alu.
            end
            default: begin
                ctrl.pc_src = pc_src_plus_4;  // unknown opcode, skip it.
            end
        endcase

        if (rst) begin
            ctrl.reg_we = 1'b0;       // no writes while in reset.
            ctrl.mem_we = 1'b0;
        end
    end

endmodule

//--- src/riscv_core.sv
module riscv_core import riscv_pkg::*; #(
    parameter logic [31:0] reset_pc = 32'h0000_0000
) (
    input  logic        clk,
    input  logic        rst,
    output logic [31:0] pc,
    input  logic [31:0] instr,
    output logic [31:0] mem_addr,
    output logic [31:0] write_data,
    output logic        mem_we,
    input  logic [31:0] read_data
);

    ctrl_t      ctrl;         // decoded controls for this instruction.
    alu_flags_t alu_flags;    // a - b flags for branches.

    assign mem_we = ctrl.mem_we;

    control_unit u_control_unit (
        .rst       (rst),
        .instr     (instr),
        .alu_flags (alu_flags),
        .ctrl      (ctrl)
    );

    datapath #(
        .reset_pc (reset_pc)
    ) u_datapath (
        .clk        (clk),
        .rst        (rst),
        .instr      (instr),
        .read_data  (read_data),
        .ctrl       (ctrl),
        .pc         (pc),
        .alu_out    (mem_addr),   // alu result is the data address.
        .alu_flags  (alu_flags),
        .write_data (write_data)
    );

endmodule

//--- tests/tb_clock.sv
module tb_clock (
    output logic clk
);

    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk; // 40 ns period.
    end

endmodule

//--- tests/tb_checker.sv
module tb_checker (
    input  logic        clk,
    input  logic        mem_we,
    input  logic [31:0] mem_addr,
    input  logic [31:0] write_data,
    output int          mismatch_count,
    output int          unexpected_count
);

    timeunit 1ns;
    timeprecision 100ps;

    int store_num = 0;            // stores seen so far.

    initial begin
        mismatch_count   = 0;
        unexpected_count = 0;
    end

    // a store completes on this edge and is compared before the pc moves.
    always @(posedge clk) begin
        logic [31:0] exp_a;
        logic [31:0] exp_d;
        if (mem_we === 1'b1) begin // reset cycles included.
            if (tb_top.exp_addr.size() == 0) begin
                $display("unexpected store at %0t: %h <= %h", $time, mem_addr, write_data);
                unexpected_count++;
            end else begin
                exp_a = tb_top.exp_addr.pop_front();
                exp_d = tb_top.exp_data.pop_front();
                if (mem_addr !== exp_a || write_data !== exp_d) begin
                    $display("MISMATCH at %0t: store %0d expected %h <= %h, got %h <= %h",
                             $time, store_num, exp_a, exp_d, mem_addr, write_data);
                    mismatch_count++;
                end
            end
            store_num++;
        end
    end

endmodule

//--- tests/core_assertions.sv
module core_assertions import riscv_pkg::*; #(
    parameter logic [31:0] reset_pc = 32'h0000_0000
) (
    input logic        clk,
    input logic        rst,
    input logic [31:0] pc,
    input logic        mem_we,
    input ctrl_t       ctrl
);

    timeunit 1ns;
    timeprecision 100ps;

    int fail_count = 0;           // read by tb_top at the end.

    // the first instruction after reset writes a register, so a missing gate shows here.
    a_no_write_in_reset: assert property (@(posedge clk) rst |-> !mem_we && !ctrl.reg_we)
        else begin
            $error("store or register write enabled during reset");
            fail_count++;
        end

    a_pc_aligned: assert property (@(posedge clk) disable iff (rst) pc[1:0] == 2'b00)
        else begin
            $error("pc not word aligned");
            fail_count++;
        end

    a_first_fetch: assert property (@(posedge clk) $fell(rst) |-> pc == reset_pc)
        else begin
            $error("first fetch after reset not at reset_pc");
            fail_count++;
        end

    a_we_known: assert property (@(posedge clk) disable iff (rst) !$isunknown({mem_we, pc}))
        else begin
            $error("store strobe or pc unknown");
            fail_count++;
        end

endmodule

bind riscv_core core_assertions #(.reset_pc(reset_pc)) i_core_assertions (
    .clk    (clk),
    .rst    (rst),
    .pc     (pc),
    .mem_we (mem_we),
    .ctrl   (ctrl)
);

//--- tests/tb_top.sv
module tb_top;

    timeunit 1ns;
    timeprecision 100ps;

    localparam logic [31:0] reset_pc = 32'h0000_0000;

    logic        clk;
    logic        rst;
    logic [31:0] pc;
    logic [31:0] instr;
    logic [31:0] mem_addr;
    logic [31:0] write_data;
    logic        mem_we;
    logic [31:0] read_data;

    logic [31:0] imem [0:255];    // word indexed by pc[9:2].
    logic [31:0] dmem [0:255];    // word indexed by mem_addr[9:2].
    logic [31:0] exp_addr [$];    // expected stores, program order.
    logic [31:0] exp_data [$];
    logic [31:0] halt_addr;
    int          mismatch_count;
    int          unexpected_count;

    tb_clock i_clock (.clk(clk));

    riscv_core #(.reset_pc(reset_pc)) i_dut (
        .clk        (clk),
        .rst        (rst),
        .pc         (pc),
        .instr      (instr),
        .mem_addr   (mem_addr),
        .write_data (write_data),
        .mem_we     (mem_we),
        .read_data  (read_data)
    );

    tb_checker i_checker (
        .clk              (clk),
        .mem_we           (mem_we),
        .mem_addr         (mem_addr),
        .write_data       (write_data),
        .mismatch_count   (mismatch_count),
        .unexpected_count (unexpected_count)
    );

    assign instr     = imem[pc[9:2]];       // combinational fetch.
    assign read_data = dmem[mem_addr[9:2]]; // combinational load.

    always @(posedge clk) begin
        if (mem_we === 1'b1) begin
            dmem[mem_addr[9:2]] <= write_data;
        end
    end

    function automatic bit load_test_file();
        int          fd;
        int          n;
        string       line;
        byte         kind;
        logic [31:0] a;
        logic [31:0] d;
        fd = $fopen("tests/core_stim.txt", "r");
        if (fd == 0) begin
            return 1'b0;
        end
        while (!$feof(fd)) begin
            n = $fgets(line, fd);
            if (n > 0 && $sscanf(line, "%c %h %h", kind, a, d) == 3) begin
                case (kind)
                    "I": imem[a[9:2]] = d;
                    "D": dmem[a[9:2]] = d;
                    "S": begin
                        exp_addr.push_back(a);
                        exp_data.push_back(d);
                    end
                    "H": halt_addr = a;
                    default: ;
                endcase
            end
        end
        $fclose(fd);
        return 1'b1;
    endfunction

    initial begin
        int missing;
        int bad_halt;
        int asrt;
        int total;
        bit halted;
        rst       = 1'b1;
        halted    = 1'b0;
        halt_addr = 32'hffff_fffc;
        for (int i = 0; i < 256; i++) begin
            imem[i] = 32'h0000_0013 | (i << 22);  // nop tagged with its byte address.
            dmem[i] = 32'h5a00_0000 ^ (i << 2);  // byte address in the low bits.
        end
        if (!load_test_file()) begin
            $display("could not open the stimulus file");
            $display("sim failed");
            $finish;
        end else begin
            repeat (10) @(posedge clk);
            rst <= 1'b0;
            for (int c = 0; c < 2000 && !halted; c++) begin
                @(negedge clk);
                if (pc === halt_addr) halted = 1'b1;
            end
            if (!halted) begin
                $display("timeout: the core never reached the halt address %h", halt_addr);
                $display("sim failed");
                $finish;
            end else begin
                repeat (2) @(negedge clk);          // let the self-loop settle.
                missing  = exp_addr.size();
                bad_halt = (pc !== halt_addr) ? 1 : 0;
                asrt     = i_dut.i_core_assertions.fail_count;
                if (missing != 0) $display("%0d expected stores never happened", missing);
                if (bad_halt != 0) $display("pc left the halt address, pc = %h", pc);
                total = mismatch_count + unexpected_count + missing + bad_halt + asrt;
                $display("errors: mismatch=%0d unexpected=%0d missing=%0d halt=%0d assert=%0d",
                         mismatch_count, unexpected_count, missing, bad_halt, asrt);
                if (total == 0) begin
                    $display("sim passed");
                end else begin
                    $display("sim failed");
                end
                $finish;
            end
        end
    end

endmodule

//--- tests/core_stim.txt
# kind address word; I program word, D initial data, S expected store, H halt address
I 00000000 10000513
I 00000004 00500093
I 00000008 ffd00113
I 0000000c 40208233
I 00000010 00121233
I 00000014 0f024213
I 00000018 00452023
I 0000001c 001155b3
I 00000020 00112433
I 00000024 008585b3
I 00000028 00b52223
I 0000002c 10052803
I 00000030 00780813
I 00000034 01052423
I 00000038 00108463
I 0000003c 00052623
I 00000040 00109463
I 00000044 0020c463
I 00000048 00114463
I 0000004c 00052623
I 00000050 00209463
I 00000054 00052623
I 00000058 00208463
I 0000005c 00152623
I 00000060 0080096f
I 00000064 00052823
I 00000068 07500993
I 0000006c 00098a67
I 00000070 00052823
I 00000074 012a0a33
I 00000078 01452823
I 0000007c abcdeab7
I 00000080 123aea93
I 00000084 01552a23
I 00000088 0000006f
D 00000200 12345678
S 00000100 000001f0
S 00000104 08000000
S 00000108 1234567f
S 0000010c 00000005
S 00000110 000000d4
S 00000114 abcde123
H 00000088 00000000

//--- files.f
src/riscv_pkg.sv
src/alu.sv
src/extend.sv
src/regfile.sv
src/datapath.sv
src/control_unit.sv
src/riscv_core.sv
tests/tb_clock.sv
tests/tb_checker.sv
tests/core_assertions.sv
tests/tb_top.sv
